// ==== l15_adapter_defines.svh ====
`ifndef L15_ADAPTER_DEFINES_SVH
`define L15_ADAPTER_DEFINES_SVH

// Physical address and request data
`define L15_ADDR_W        40
`define L15_DATA_W        64
`define L15_BE_W          8

// One bit gives two L1.5 thread IDs
`define L15_TID_W         1

`define REQ_ID_W          4   // Cache request ID
`define PORT_ID_W         3   // Requesting port

// Pending data-cache invalidations
`define INVAL_FIFO_DEPTH  4

// Byte swap inside each 64-bit word, 0 disables
`define L15_SWAP_ENDIAN   1

`endif

// ==== l15_adapter_pkg.sv ====
`include "l15_adapter_defines.svh"

package l15_adapter_pkg;

    typedef logic [`L15_ADDR_W-1:0] addr_t;
    typedef logic [`L15_DATA_W-1:0] dword_t;
    typedef logic [`L15_BE_W-1:0]   be_t;
    typedef logic [`L15_TID_W-1:0]  l15_tid_t;
    typedef logic [`REQ_ID_W-1:0]   req_id_t;
    typedef logic [`PORT_ID_W-1:0]  port_id_t;

    // Codes 0..3 are 1, 2, 4, 8 bytes, code 7 is 16 bytes
    typedef logic [2:0] l15_size_t;

    typedef enum logic [4:0] {
        L15_LOAD_RQ  = 5'b00000,
        L15_STORE_RQ = 5'b00001
    } l15_rqtype_e;

    typedef enum logic [3:0] {
        L15_LOAD_RET  = 4'b0000,
        L15_EVICT_REQ = 4'b0011,  // Invalidation only, no response
        L15_ST_ACK    = 4'b0100,
        L15_ERR_RET   = 4'b1100
    } l15_rtntype_e;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_HEADER_ACK,
        WAIT_ACK
    } req_state_e;

    // Reverse byte order of one 64-bit word
    function automatic dword_t swap_bytes(input dword_t d);
        dword_t r;
        for (int i = 0; i < 8; i++) begin
            r[8*i +: 8] = d[8*(7-i) +: 8];
        end
        return r;
    endfunction

endpackage

// ==== l15_adapter_if.sv ====
`timescale 1ns/100ps

// Thread-ID allocation, recording and lookup
interface tid_if;
    import l15_adapter_pkg::*;

    logic     avail;      // At least one ID free
    l15_tid_t alloc_tid;  // ID used by the next request
    logic     grant;
    req_id_t  rec_id;
    port_id_t rec_pid;
    logic     rel;        // Free rel_tid on this edge
    l15_tid_t rel_tid;
    req_id_t  lk_id;
    port_id_t lk_pid;

    modport fsm    (input avail, output grant, rec_id, rec_pid);
    modport tbl    (output avail, alloc_tid, lk_id, lk_pid,
                    input grant, rec_id, rec_pid, rel, rel_tid);
    modport router (output rel, rel_tid, input lk_id, lk_pid);
endinterface

// L1.5 return channel
interface l15_rtrn_if;
    import l15_adapter_pkg::*;

    logic         val;
    l15_rtntype_e rtntype;
    l15_tid_t     threadid;
    dword_t       data0;
    dword_t       data1;
    logic         inval;       // Data-cache line invalidation
    addr_t        inval_addr;

    modport router (input val, rtntype, threadid, data0, data1, inval);
    modport fifo   (input inval_addr);
endinterface

// ==== l15_req_fsm.sv ====
`timescale 1ns/100ps

module l15_req_fsm (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      req_valid_i,
    input  l15_adapter_pkg::req_id_t  req_id_i,
    input  l15_adapter_pkg::port_id_t req_pid_i,
    input  logic                      header_ack_i,
    input  logic                      ack_i,
    output logic                      l15_val_o,
    output logic                      req_ready_o,
    tid_if.fsm                        tid
);
    import l15_adapter_pkg::*;

    req_state_e state_q, state_d;
    logic       done;  // Final ack of the pending request

    always_comb begin
        state_d   = state_q;
        l15_val_o = 1'b0;
        done      = 1'b0;
        case (state_q)
            IDLE: begin
                if (req_valid_i && tid.avail) begin
                    l15_val_o = 1'b1;
                    if (header_ack_i) begin
                        if (ack_i) begin
                            done = 1'b1;
                        end else begin
                            state_d = WAIT_ACK;
                        end
                    end else begin
                        state_d = WAIT_HEADER_ACK;
                    end
                end
            end
            WAIT_HEADER_ACK: begin
                l15_val_o = 1'b1;
                if (req_valid_i && header_ack_i) begin
                    if (ack_i) begin
                        done    = 1'b1;
                        state_d = IDLE;
                    end else begin
                        state_d = WAIT_ACK;
                    end
                end
            end
            WAIT_ACK: begin
                // Fields held, valid dropped
                if (req_valid_i && ack_i) begin
                    done    = 1'b1;
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    assign req_ready_o = done;
    assign tid.grant   = done;
    assign tid.rec_id  = req_id_i;
    assign tid.rec_pid = req_pid_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // A request put on the L1.5 port is only abandoned by its ack
    a_no_drop_without_ack: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (l15_val_o && !ack_i) |=> (state_q != IDLE)
    );

endmodule

// ==== l15_tid_table.sv ====
`timescale 1ns/100ps
`include "l15_adapter_defines.svh"

module l15_tid_table (
    input logic clk_i,
    input logic rst_ni,
    tid_if.tbl  tid
);
    import l15_adapter_pkg::*;

    localparam int unsigned NUM_TIDS = 1 << `L15_TID_W;

    logic [NUM_TIDS-1:0] busy_q;       // One bit per request in flight
    l15_tid_t            sel_q;        // Last offered ID
    l15_tid_t            lowest_free;
    req_id_t             id_q  [NUM_TIDS];
    port_id_t            pid_q [NUM_TIDS];

    always_comb begin
        lowest_free = '0;
        for (int i = NUM_TIDS - 1; i >= 0; i--) begin
            if (!busy_q[i]) begin
                lowest_free = l15_tid_t'(i);
            end
        end
    end

    // Keep offering the same ID until it is granted, so a release of a
    // lower ID cannot change the thread ID under a pending request
    assign tid.alloc_tid = busy_q[sel_q] ? lowest_free : sel_q;
    assign tid.avail     = ~&busy_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= '0;
            sel_q  <= '0;
        end else begin
            sel_q <= tid.alloc_tid;
            if (tid.grant) begin
                busy_q[tid.alloc_tid] <= 1'b1;
            end
            if (tid.rel) begin
                busy_q[tid.rel_tid] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (tid.grant) begin
            id_q[tid.alloc_tid]  <= tid.rec_id;
            pid_q[tid.alloc_tid] <= tid.rec_pid;
        end
    end

    assign tid.lk_id  = id_q[tid.rel_tid];
    assign tid.lk_pid = pid_q[tid.rel_tid];

    a_grant_needs_free_id: assert property (
        @(posedge clk_i) disable iff (!rst_ni) tid.grant |-> tid.avail
    );

    // Every return must match a request still in flight
    a_release_busy_id: assert property (
        @(posedge clk_i) disable iff (!rst_ni) tid.rel |-> busy_q[tid.rel_tid]
    );

endmodule

// ==== l15_store_formatter.sv ====
`timescale 1ns/100ps
`include "l15_adapter_defines.svh"

module l15_store_formatter (
    input  logic                         req_write_i,
    input  logic                         req_cacheable_i,
    input  l15_adapter_pkg::addr_t       req_addr_i,
    input  l15_adapter_pkg::l15_size_t   req_size_i,
    input  l15_adapter_pkg::dword_t      req_wdata_i,
    input  l15_adapter_pkg::be_t         req_be_i,
    output l15_adapter_pkg::l15_rqtype_e l15_rqtype_o,
    output logic                         l15_nc_o,
    output l15_adapter_pkg::l15_size_t   l15_size_o,
    output l15_adapter_pkg::addr_t       l15_address_o,
    output l15_adapter_pkg::dword_t      l15_data_o
);
    import l15_adapter_pkg::*;

    logic [3:0] num_ones;    // Set byte enables
    logic [2:0] first_one;   // Lowest set byte
    logic [2:0] st_ofs;
    logic [5:0] bit_ofs;
    l15_size_t  st_size;
    dword_t     rep_data;

    always_comb begin
        num_ones  = '0;
        first_one = '0;
        for (int i = `L15_BE_W - 1; i >= 0; i--) begin
            num_ones = num_ones + 4'(req_be_i[i]);
            if (req_be_i[i]) begin
                first_one = 3'(i);
            end
        end
    end

    always_comb begin
        st_ofs = first_one;
        case (num_ones)
            4'd1:    st_size = 3'd0;
            4'd2:    st_size = 3'd1;
            4'd4:    st_size = 3'd2;
            4'd8: begin
                st_size = 3'd3;
                st_ofs  = '0;  // Full dword
            end
            default: begin
                st_size = 3'd7;
                st_ofs  = '0;
            end
        endcase
    end

    assign bit_ofs = {st_ofs, 3'b000};

    // Uncacheable short stores carry their chunk in every lane
    always_comb begin
        rep_data = req_wdata_i;
        if (req_write_i && !req_cacheable_i) begin
            case (st_size)
                3'd0:    rep_data = {8{req_wdata_i[bit_ofs +: 8]}};
                3'd1:    rep_data = {4{req_wdata_i[bit_ofs +: 16]}};
                3'd2:    rep_data = {2{req_wdata_i[bit_ofs +: 32]}};
                default: rep_data = req_wdata_i;
            endcase
        end
    end

    assign l15_rqtype_o  = req_write_i ? L15_STORE_RQ : L15_LOAD_RQ;
    assign l15_nc_o      = ~req_cacheable_i;
    assign l15_size_o    = req_write_i ? st_size :
                           (req_size_i == 3'd4) ? 3'd7 : req_size_i;  // 16B load
    assign l15_address_o = req_write_i ? {req_addr_i[`L15_ADDR_W-1:3], st_ofs} : req_addr_i;
    assign l15_data_o    = (`L15_SWAP_ENDIAN != 0) ? swap_bytes(rep_data) : rep_data;

endmodule

// ==== l15_resp_router.sv ====
`timescale 1ns/100ps
`include "l15_adapter_defines.svh"

module l15_resp_router (
    input  logic                        resp_ready_i,
    input  logic                        fifo_full_i,
    l15_rtrn_if.router                  rtrn,
    tid_if.router                       tid,
    output logic                        resp_valid_o,
    output l15_adapter_pkg::req_id_t    resp_id_o,
    output l15_adapter_pkg::port_id_t   resp_pid_o,
    output logic                        resp_err_o,
    output logic [2*`L15_DATA_W-1:0]    resp_data_o,
    output logic                        l15_req_ack_o,
    output logic                        fifo_push_o
);
    import l15_adapter_pkg::*;

    logic evict_only;  // Invalidation without a response
    logic fifo_ok;

    assign evict_only = (rtrn.rtntype == L15_EVICT_REQ);
    assign fifo_ok    = ~fifo_full_i;

    always_comb begin
        if (evict_only) begin
            resp_valid_o  = 1'b0;
            l15_req_ack_o = rtrn.val & fifo_ok;
        end else if (rtrn.inval) begin
            // Response and invalidation leave together
            resp_valid_o  = rtrn.val & fifo_ok;
            l15_req_ack_o = rtrn.val & fifo_ok & resp_ready_i;
        end else begin
            resp_valid_o  = rtrn.val;
            l15_req_ack_o = rtrn.val & resp_ready_i;
        end
    end

    assign fifo_push_o = l15_req_ack_o & rtrn.inval;

    // Consumed response frees its thread ID
    assign tid.rel     = l15_req_ack_o & ~evict_only;
    assign tid.rel_tid = rtrn.threadid;

    assign resp_id_o   = tid.lk_id;
    assign resp_pid_o  = tid.lk_pid;
    assign resp_err_o  = (rtrn.rtntype == L15_ERR_RET);
    assign resp_data_o = (`L15_SWAP_ENDIAN != 0) ?
                         {swap_bytes(rtrn.data1), swap_bytes(rtrn.data0)} :
                         {rtrn.data1, rtrn.data0};

endmodule

// ==== l15_inval_fifo.sv ====
`timescale 1ns/100ps
`include "l15_adapter_defines.svh"

module l15_inval_fifo (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   push_i,
    l15_rtrn_if.fifo               rtrn,
    output logic                   full_o,
    input  logic                   inval_ready_i,
    output logic                   inval_valid_o,
    output l15_adapter_pkg::addr_t inval_addr_o
);
    import l15_adapter_pkg::*;

    localparam int unsigned DEPTH = `INVAL_FIFO_DEPTH;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    addr_t                mem [DEPTH];
    logic [PTR_W-1:0]     wr_ptr, rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                 pop;

    assign full_o        = (count == DEPTH);
    assign inval_valid_o = (count != 0);
    assign pop           = inval_valid_o & inval_ready_i;
    assign inval_addr_o  = mem[rd_ptr];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + push_i - pop;
        end
    end

    // Line-aligned address
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr] <= {rtrn.inval_addr[`L15_ADDR_W-1:4], 4'b0000};
        end
    end

    a_no_push_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o
    );

endmodule

// ==== l15_adapter_top.sv ====
`timescale 1ns/100ps
`include "l15_adapter_defines.svh"

module l15_adapter_top (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    // Cache request port
    input  logic                          req_valid_i,
    output logic                          req_ready_o,
    input  l15_adapter_pkg::req_id_t      req_id_i,
    input  l15_adapter_pkg::port_id_t     req_pid_i,
    input  logic                          req_write_i,
    input  logic                          req_cacheable_i,
    input  l15_adapter_pkg::addr_t        req_addr_i,
    input  l15_adapter_pkg::l15_size_t    req_size_i,
    input  l15_adapter_pkg::dword_t       req_wdata_i,
    input  l15_adapter_pkg::be_t          req_be_i,
    // Cache response port
    input  logic                          resp_ready_i,
    output logic                          resp_valid_o,
    output l15_adapter_pkg::req_id_t      resp_id_o,
    output l15_adapter_pkg::port_id_t     resp_pid_o,
    output logic                          resp_err_o,
    output logic [2*`L15_DATA_W-1:0]      resp_data_o,
    // Invalidations toward the cache
    input  logic                          inval_ready_i,
    output logic                          inval_valid_o,
    output l15_adapter_pkg::addr_t        inval_addr_o,
    // L1.5 request
    output logic                          l15_val_o,
    output l15_adapter_pkg::l15_rqtype_e  l15_rqtype_o,
    output logic                          l15_nc_o,
    output l15_adapter_pkg::l15_size_t    l15_size_o,
    output l15_adapter_pkg::l15_tid_t     l15_threadid_o,
    output l15_adapter_pkg::addr_t        l15_address_o,
    output l15_adapter_pkg::dword_t       l15_data_o,
    input  logic                          l15_header_ack_i,
    input  logic                          l15_ack_i,
    output logic                          l15_req_ack_o,
    // L1.5 return
    input  logic                          l15_rtrn_val_i,
    input  l15_adapter_pkg::l15_rtntype_e l15_rtrn_type_i,
    input  l15_adapter_pkg::l15_tid_t     l15_rtrn_threadid_i,
    input  l15_adapter_pkg::dword_t       l15_rtrn_data0_i,
    input  l15_adapter_pkg::dword_t       l15_rtrn_data1_i,
    input  logic                          l15_rtrn_inval_i,
    input  l15_adapter_pkg::addr_t        l15_rtrn_inval_addr_i
);

    logic fifo_push;
    logic fifo_full;

    tid_if      tid_bus ();
    l15_rtrn_if rtrn_bus ();

    assign rtrn_bus.val        = l15_rtrn_val_i;
    assign rtrn_bus.rtntype    = l15_rtrn_type_i;
    assign rtrn_bus.threadid   = l15_rtrn_threadid_i;
    assign rtrn_bus.data0      = l15_rtrn_data0_i;
    assign rtrn_bus.data1      = l15_rtrn_data1_i;
    assign rtrn_bus.inval      = l15_rtrn_inval_i;
    assign rtrn_bus.inval_addr = l15_rtrn_inval_addr_i;

    assign l15_threadid_o = tid_bus.alloc_tid;  // Stable while a request is pending

    l15_req_fsm u_req_fsm (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_valid_i  (req_valid_i),
        .req_id_i     (req_id_i),
        .req_pid_i    (req_pid_i),
        .header_ack_i (l15_header_ack_i),
        .ack_i        (l15_ack_i),
        .l15_val_o    (l15_val_o),
        .req_ready_o  (req_ready_o),
        .tid          (tid_bus.fsm)
    );

    l15_tid_table u_tid_table (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .tid    (tid_bus.tbl)
    );

    l15_store_formatter u_store_formatter (
        .req_write_i     (req_write_i),
        .req_cacheable_i (req_cacheable_i),
        .req_addr_i      (req_addr_i),
        .req_size_i      (req_size_i),
        .req_wdata_i     (req_wdata_i),
        .req_be_i        (req_be_i),
        .l15_rqtype_o    (l15_rqtype_o),
        .l15_nc_o        (l15_nc_o),
        .l15_size_o      (l15_size_o),
        .l15_address_o   (l15_address_o),
        .l15_data_o      (l15_data_o)
    );

    l15_resp_router u_resp_router (
        .resp_ready_i  (resp_ready_i),
        .fifo_full_i   (fifo_full),
        .rtrn          (rtrn_bus.router),
        .tid           (tid_bus.router),
        .resp_valid_o  (resp_valid_o),
        .resp_id_o     (resp_id_o),
        .resp_pid_o    (resp_pid_o),
        .resp_err_o    (resp_err_o),
        .resp_data_o   (resp_data_o),
        .l15_req_ack_o (l15_req_ack_o),
        .fifo_push_o   (fifo_push)
    );

    l15_inval_fifo u_inval_fifo (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .push_i        (fifo_push),
        .rtrn          (rtrn_bus.fifo),
        .full_o        (fifo_full),
        .inval_ready_i (inval_ready_i),
        .inval_valid_o (inval_valid_o),
        .inval_addr_o  (inval_addr_o)
    );

endmodule

// ==== tb_l15_adapter.sv ====
`timescale 1ns/100ps
`include "l15_adapter_defines.svh"

module tb_l15_adapter;
    import l15_adapter_pkg::*;

    localparam int NUM_XACT       = 49;            // Requests and returns issued
    localparam int TIMEOUT_CYCLES = NUM_XACT * 40;

    logic           clk_i = 1'b0;
    logic           rst_ni;
    logic           req_valid_i, req_ready_o, req_write_i, req_cacheable_i;
    req_id_t        req_id_i, resp_id_o;
    port_id_t       req_pid_i, resp_pid_o;
    addr_t          req_addr_i, inval_addr_o, l15_address_o, l15_rtrn_inval_addr_i;
    l15_size_t      req_size_i, l15_size_o;
    dword_t         req_wdata_i, l15_data_o, l15_rtrn_data0_i, l15_rtrn_data1_i;
    be_t            req_be_i;
    logic           resp_ready_i, resp_valid_o, resp_err_o;
    logic [127:0]   resp_data_o;
    logic           inval_ready_i, inval_valid_o;
    logic           l15_val_o, l15_nc_o, l15_header_ack_i, l15_ack_i, l15_req_ack_o;
    l15_rqtype_e    l15_rqtype_o;
    l15_tid_t       l15_threadid_o, l15_rtrn_threadid_i;
    logic           l15_rtrn_val_i, l15_rtrn_inval_i;
    l15_rtntype_e   l15_rtrn_type_i;

    logic [31:0]    lfsr_q = 32'hab56_67d0;
    logic [112:0]   exp_req [$];     // {rqtype, nc, size, address, data}
    logic [135:0]   exp_resp [$];    // {id, pid, err, data}
    addr_t          exp_inval [$];
    logic           inflight [2];
    req_id_t        sent_id [2];
    port_id_t       sent_pid [2];
    int             err_cnt = 0;
    int             chk_cnt = 0;
    int             errs_base = 0;
    int             cycle_cnt = 0;

    l15_adapter_top DUT (.*);

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic value_fail(input string msg);
        $display("Fail at time %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic other_fail(input string msg);
        $display("Error: %s", msg);
        err_cnt++;
    endtask

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i]   = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic dword_t ref_swap(input dword_t d);
        dword_t r;
        if (`L15_SWAP_ENDIAN == 0) begin
            return d;
        end
        for (int i = 0; i < 8; i++) begin
            r[63-8*i -: 8] = d[8*i +: 8];
        end
        return r;
    endfunction

    // Store size, offset-aligned address and lane data
    function automatic logic [106:0] ref_store(input logic cacheable, input addr_t addr,
                                               input dword_t wdata, input be_t be);
        int        n;
        int        ofs;
        l15_size_t sz;
        dword_t    d;
        n   = $countones(be);
        ofs = 0;
        for (int i = 7; i >= 0; i--) begin
            if (be[i]) begin
                ofs = i;
            end
        end
        case (n)
            1:       sz = 3'd0;
            2:       sz = 3'd1;
            4:       sz = 3'd2;
            8:       sz = 3'd3;
            default: begin
                sz  = 3'd7;
                ofs = 0;
            end
        endcase
        d = wdata;
        if (!cacheable && sz != 3'd3 && sz != 3'd7) begin
            for (int i = 0; i < 8; i++) begin
                d[8*i +: 8] = wdata[8*(ofs + i % n) +: 8];  // Chunk repeated per lane
            end
        end
        return {sz, addr[39:3], 3'(ofs), ref_swap(d)};
    endfunction

    task automatic next_cycle();
        @(posedge clk_i);
        #0.5;
    endtask

    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (req_ready_o) begin
                if (exp_req.size() == 0) begin
                    other_fail("request accepted while none was pending");
                end else begin
                    chk_cnt++;
                    assert ({l15_rqtype_o, l15_nc_o, l15_size_o, l15_address_o, l15_data_o}
                            == exp_req[0]) else begin
                        value_fail($sformatf("L1.5 request %h, expected %h",
                            {l15_rqtype_o, l15_nc_o, l15_size_o, l15_address_o, l15_data_o},
                            exp_req[0]));
                    end
                    void'(exp_req.pop_front());
                end
            end
            if (resp_valid_o && resp_ready_i) begin
                if (exp_resp.size() == 0) begin
                    other_fail("response delivered with no return pending");
                end else begin
                    chk_cnt++;
                    assert ({resp_id_o, resp_pid_o, resp_err_o, resp_data_o} == exp_resp[0])
                    else begin
                        value_fail($sformatf("response %h, expected %h",
                            {resp_id_o, resp_pid_o, resp_err_o, resp_data_o}, exp_resp[0]));
                    end
                    void'(exp_resp.pop_front());
                end
            end
            if (inval_valid_o && inval_ready_i) begin
                if (exp_inval.size() == 0) begin
                    other_fail("invalidation sent that was never requested");
                end else begin
                    chk_cnt++;
                    assert (inval_addr_o == exp_inval[0]) else begin
                        value_fail($sformatf("inval_addr_o %h, expected %h",
                                             inval_addr_o, exp_inval[0]));
                    end
                    void'(exp_inval.pop_front());
                end
            end
        end
    end

    task automatic drive_req(input logic wr, input logic c, input addr_t a, input l15_size_t sz,
                             input dword_t w, input be_t be, input req_id_t id,
                             input port_id_t pid);
        if (wr) begin
            exp_req.push_back({L15_STORE_RQ, ~c, ref_store(c, a, w, be)});
        end else begin
            exp_req.push_back({L15_LOAD_RQ, ~c, (sz == 3'd4) ? 3'd7 : sz, a, ref_swap(w)});
        end
        req_write_i     = wr;
        req_cacheable_i = c;
        req_addr_i      = a;
        req_size_i      = sz;
        req_wdata_i     = w;
        req_be_i        = be;
        req_id_i        = id;
        req_pid_i       = pid;
        req_valid_i     = 1'b1;
    endtask

    // L1.5 side of the request, random header-ack and ack delays
    task automatic complete_req(output l15_tid_t t);
        logic [63:0] hdr_dly;
        logic [63:0] ack_dly;
        @(negedge clk_i);
        while (!l15_val_o) begin
            next_cycle();
            @(negedge clk_i);
        end
        t = l15_threadid_o;
        chk_cnt++;
        assert (!inflight[t]) else other_fail($sformatf("thread ID %0d reused in flight", t));
        rand_bits(2, hdr_dly);
        rand_bits(2, ack_dly);
        next_cycle();
        repeat (int'(hdr_dly[1:0])) next_cycle();
        l15_header_ack_i = 1'b1;
        if (ack_dly[1:0] == 2'd0) begin
            l15_ack_i = 1'b1;
        end else begin
            next_cycle();
            l15_header_ack_i = 1'b0;
            repeat (int'(ack_dly[1:0]) - 1) next_cycle();
            l15_ack_i = 1'b1;
        end
        @(negedge clk_i);
        chk_cnt += 2;
        assert (req_ready_o) else value_fail("req_ready_o low on the final ack");
        assert (l15_threadid_o == t) else value_fail("l15_threadid_o changed during request");
        next_cycle();
        l15_header_ack_i = 1'b0;
        l15_ack_i        = 1'b0;
        req_valid_i      = 1'b0;
        inflight[t]      = 1'b1;
        sent_id[t]       = req_id_i;
        sent_pid[t]      = req_pid_i;
    endtask

    task automatic send_return(input l15_rtntype_e rt, input l15_tid_t t, input logic inv,
                               input addr_t ia, input int hold, input logic block_resp);
        logic [63:0] d0;
        logic [63:0] d1;
        rand_bits(64, d0);
        rand_bits(64, d1);
        if (rt != L15_EVICT_REQ) begin
            exp_resp.push_back({sent_id[t], sent_pid[t], rt == L15_ERR_RET,
                                ref_swap(d1), ref_swap(d0)});
        end
        if (inv) begin
            exp_inval.push_back({ia[39:4], 4'b0000});
        end
        l15_rtrn_type_i       = rt;
        l15_rtrn_threadid_i   = t;
        l15_rtrn_data0_i      = d0;
        l15_rtrn_data1_i      = d1;
        l15_rtrn_inval_i      = inv;
        l15_rtrn_inval_addr_i = ia;
        l15_rtrn_val_i        = 1'b1;
        if (block_resp) begin
            resp_ready_i = 1'b0;
        end
        repeat (hold) begin
            @(negedge clk_i);
            chk_cnt++;
            assert (!l15_req_ack_o) else value_fail("return acknowledged while blocked");
            next_cycle();
        end
        resp_ready_i = 1'b1;
        if (hold > 0) begin
            inval_ready_i = 1'b1;  // Drain the full FIFO
        end
        @(negedge clk_i);
        while (!l15_req_ack_o) begin
            next_cycle();
            @(negedge clk_i);
        end
        if (rt == L15_EVICT_REQ) begin
            chk_cnt++;
            assert (!resp_valid_o) else value_fail("evict-only return raised resp_valid_o");
        end
        next_cycle();
        l15_rtrn_val_i = 1'b0;
        if (rt != L15_EVICT_REQ) begin
            inflight[t] = 1'b0;
        end
    endtask

    task automatic finish_test(input string name);
        if (err_cnt == errs_base) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, err_cnt - errs_base);
        end
        errs_base = err_cnt;
    endtask

    initial begin
        logic [63:0] r;
        logic [63:0] w;
        logic [63:0] c;
        int          nb;
        int          ofs;
        l15_tid_t    t0;
        l15_tid_t    t1;
        l15_tid_t    t2;
        rst_ni = 1'b0;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_cacheable_i = 1'b0;
        req_id_i = '0;
        req_pid_i = '0;
        req_addr_i = '0;
        req_size_i = '0;
        req_wdata_i = '0;
        req_be_i = '0;
        resp_ready_i = 1'b1;
        inval_ready_i = 1'b1;
        l15_header_ack_i = 1'b0;
        l15_ack_i = 1'b0;
        l15_rtrn_val_i = 1'b0;
        l15_rtrn_type_i = L15_LOAD_RET;
        l15_rtrn_threadid_i = '0;
        l15_rtrn_data0_i = '0;
        l15_rtrn_data1_i = '0;
        l15_rtrn_inval_i = 1'b0;
        l15_rtrn_inval_addr_i = '0;
        inflight[0] = 1'b0;
        inflight[1] = 1'b0;
        repeat (8) @(posedge clk_i);
        #0.5;
        rst_ni = 1'b1;
        next_cycle();

        for (int s = 0; s <= 4; s++) begin
            rand_bits(40, r);
            rand_bits(64, w);
            rand_bits(1, c);
            drive_req(1'b0, c[0], addr_t'(r), 3'(s), w, '0, 4'(s), 3'(s));
            complete_req(t0);
            send_return(L15_LOAD_RET, t0, 1'b0, '0, 0, 1'b0);
        end
        finish_test("load translation");

        for (int k = 0; k < 8; k++) begin
            rand_bits(2, r);
            nb = 1 << int'(r[1:0]);
            rand_bits(3, r);
            ofs = int'(r[2:0]) & ~(nb - 1);  // Naturally aligned chunk
            rand_bits(40, r);
            rand_bits(64, w);
            rand_bits(1, c);
            drive_req(1'b1, c[0], addr_t'(r), 3'd3, w, be_t'(((1 << nb) - 1) << ofs),
                      4'(k + 8), 3'(k));
            complete_req(t0);
            send_return(L15_ST_ACK, t0, 1'b0, '0, 0, 1'b0);
        end
        finish_test("store formatting");

        rand_bits(40, r);
        drive_req(1'b0, 1'b1, addr_t'(r), 3'd3, '0, '0, 4'h5, 3'd1);
        complete_req(t0);
        drive_req(1'b0, 1'b1, addr_t'(r) + 40'h40, 3'd4, '0, '0, 4'ha, 3'd6);
        complete_req(t1);
        send_return(L15_ERR_RET, t1, 1'b0, '0, 0, 1'b0);
        send_return(L15_LOAD_RET, t0, 1'b0, '0, 0, 1'b0);
        // Each return lands while the next request waits for its acks
        drive_req(1'b0, 1'b1, addr_t'(r) + 40'h80, 3'd3, '0, '0, 4'hb, 3'd0);
        complete_req(t0);
        for (int k = 0; k < 2; k++) begin
            drive_req(1'b0, 1'b1, addr_t'(r) + 40'h100, 3'd2, '0, '0, 4'(12 + k), 3'(k + 2));
            fork
                complete_req(t1);
                send_return(L15_LOAD_RET, t0, 1'b0, '0, 0, 1'b0);
            join
            t0 = t1;
        end
        send_return(L15_LOAD_RET, t0, 1'b0, '0, 0, 1'b0);
        finish_test("out-of-order routing");

        drive_req(1'b0, 1'b1, 40'h12_3456_7880, 3'd3, '0, '0, 4'h1, 3'd2);
        complete_req(t0);
        drive_req(1'b0, 1'b1, 40'h12_3456_78c0, 3'd3, '0, '0, 4'h2, 3'd3);
        complete_req(t1);
        drive_req(1'b1, 1'b0, 40'h00_0000_1000, 3'd3, 64'h0123_4567_89ab_cdef, 8'h0c,
                  4'h3, 3'd4);
        repeat (5) begin
            @(negedge clk_i);
            chk_cnt++;
            assert (!l15_val_o && !req_ready_o) else value_fail("request sent with no free ID");
            next_cycle();
        end
        send_return(L15_LOAD_RET, t0, 1'b0, '0, 0, 1'b0);
        complete_req(t2);
        send_return(L15_LOAD_RET, t1, 1'b0, '0, 4, 1'b1);  // Held by resp_ready_i
        send_return(L15_ST_ACK, t2, 1'b0, '0, 0, 1'b0);
        finish_test("back-pressure");

        drive_req(1'b0, 1'b1, 40'h00_0000_2000, 3'd3, '0, '0, 4'h7, 3'd5);
        complete_req(t0);
        rand_bits(40, r);
        send_return(L15_LOAD_RET, t0, 1'b1, addr_t'(r), 0, 1'b0);
        // Evictions start with an empty FIFO
        @(negedge clk_i);
        while (inval_valid_o) begin
            next_cycle();
            @(negedge clk_i);
        end
        next_cycle();
        inval_ready_i = 1'b0;
        for (int k = 0; k < `INVAL_FIFO_DEPTH + 1; k++) begin
            rand_bits(40, r);
            send_return(L15_EVICT_REQ, '0, 1'b1, addr_t'(r),
                        (k == `INVAL_FIFO_DEPTH) ? 4 : 0, 1'b0);
        end
        @(negedge clk_i);
        while (inval_valid_o) begin
            next_cycle();
            @(negedge clk_i);
        end
        next_cycle();
        finish_test("invalidations");

        chk_cnt++;
        assert (exp_req.size() == 0 && exp_resp.size() == 0 && exp_inval.size() == 0)
        else other_fail("some expected transfers never appeared at the DUT outputs");
        $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+.
l15_adapter_pkg.sv
l15_adapter_if.sv
l15_req_fsm.sv
l15_tid_table.sv
l15_store_formatter.sv
l15_resp_router.sv
l15_inval_fifo.sv
l15_adapter_top.sv
tb_l15_adapter.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the L1.5 adapter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_l15_adapter -o sim_l15_adapter

out=$(./obj_dir/sim_l15_adapter)
echo "$out"

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
